/* rtl/prbs_defines.svh */
// Width macros shared by the PRBS link tester packages.
// Included by every package that needs a word or count width.
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// PRBS word width, valid from 3 to 32.
`define PRBS_WIDTH 16

// Test length and error count width.
`define COUNT_WIDTH 16

`endif

/* rtl/prbs_pkg.sv */
// Word type and feedback rule of the Fibonacci XNOR pseudo-random sequence.
// Shared by the generator, the checker and the testbench.
`include "prbs_defines.svh"

package prbs_pkg;

    typedef logic [`PRBS_WIDTH-1:0] word_t;

    // One shift step with the XNOR of the tap bits shifted in.
    function automatic word_t next_word(input word_t cur);
        logic [31:0] w;
        logic        fb;
        // Widened copy keeps every tap index in range.
        w = 32'(cur);
        case (`PRBS_WIDTH)
            3:  fb = w[2] ^~ w[1];
            4:  fb = w[3] ^~ w[2];
            5:  fb = w[4] ^~ w[2];
            6:  fb = w[5] ^~ w[4];
            7:  fb = w[6] ^~ w[5];
            8:  fb = w[7] ^~ w[5] ^~ w[4] ^~ w[3];
            9:  fb = w[8] ^~ w[4];
            10: fb = w[9] ^~ w[6];
            11: fb = w[10] ^~ w[8];
            12: fb = w[11] ^~ w[5] ^~ w[3] ^~ w[0];
            13: fb = w[12] ^~ w[3] ^~ w[2] ^~ w[0];
            14: fb = w[13] ^~ w[4] ^~ w[2] ^~ w[0];
            15: fb = w[14] ^~ w[13];
            16: fb = w[15] ^~ w[14] ^~ w[12] ^~ w[3];
            17: fb = w[16] ^~ w[13];
            18: fb = w[17] ^~ w[10];
            19: fb = w[18] ^~ w[5] ^~ w[1] ^~ w[0];
            20: fb = w[19] ^~ w[16];
            21: fb = w[20] ^~ w[18];
            22: fb = w[21] ^~ w[20];
            23: fb = w[22] ^~ w[17];
            24: fb = w[23] ^~ w[22] ^~ w[21] ^~ w[16];
            25: fb = w[24] ^~ w[21];
            26: fb = w[25] ^~ w[5] ^~ w[1] ^~ w[0];
            27: fb = w[26] ^~ w[4] ^~ w[1] ^~ w[0];
            28: fb = w[27] ^~ w[24];
            29: fb = w[28] ^~ w[26];
            30: fb = w[29] ^~ w[5] ^~ w[3] ^~ w[0];
            31: fb = w[30] ^~ w[27];
            default: fb = w[31] ^~ w[21] ^~ w[1] ^~ w[0];
        endcase
        return {cur[`PRBS_WIDTH-2:0], fb};
    endfunction

endpackage

/* rtl/test_ctrl_pkg.sv */
// Controller state encoding and the count type for test control.
`include "prbs_defines.svh"

package test_ctrl_pkg;

    // Lengths, remaining counts and error counts.
    typedef logic [`COUNT_WIDTH-1:0] count_t;

    // Controller states.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } state_t;

endpackage

/* rtl/prbs_gen.sv */
// XNOR shift-register PRBS source, one step per transmitted word.
`timescale 1ns/1ps

module prbs_gen (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            step_i,
    output prbs_pkg::word_t data_o
);

    prbs_pkg::word_t state;

    // All zeros is a legal start for the XNOR form.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= '0;
        end else if (step_i) begin
            state <= prbs_pkg::next_word(state);
        end
    end

    assign data_o = state;

endmodule

/* rtl/prbs_check.sv */
// Self-synchronizing PRBS checker with a saturating mismatch count.
// Each word is predicted from the word received before it.
`timescale 1ns/1ps

module prbs_check (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 clear_i,
    input  logic                 valid_i,
    input  prbs_pkg::word_t      data_i,
    output test_ctrl_pkg::count_t err_count_o
);

    prbs_pkg::word_t       prev_word;
    logic                  primed;
    test_ctrl_pkg::count_t err_count;
    logic                  mismatch;

    assign mismatch = (data_i != prbs_pkg::next_word(prev_word));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control and count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            primed    <= 1'b0;
            err_count <= '0;
        end else if (clear_i) begin
            primed    <= 1'b0;
            err_count <= '0;
        end else if (valid_i) begin
            // First word after a clear only seeds.
            primed <= 1'b1;
            if (primed && mismatch && (err_count != '1)) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    // Last received word, the base for the next prediction.
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            prev_word <= data_i;
        end
    end

    assign err_count_o = err_count;

endmodule

/* rtl/test_timer.sv */
// Transmit and receive word counters, loaded with the test length.
`timescale 1ns/1ps

module test_timer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  load_i,
    input  test_ctrl_pkg::count_t len_i,
    input  logic                  busy_i,
    input  logic                  rx_step_i,
    output logic                  tx_step_o,
    output logic                  tx_done_o,
    output logic                  rx_done_o
);

    test_ctrl_pkg::count_t tx_left;
    test_ctrl_pkg::count_t rx_left;

    assign tx_done_o = (tx_left == '0);
    assign rx_done_o = (rx_left == '0);

    // One word per cycle until the length is used up.
    assign tx_step_o = busy_i && !tx_done_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_left <= '0;
        end else if (load_i) begin
            tx_left <= len_i;
        end else if (tx_step_o) begin
            tx_left <= tx_left - 1'b1;
        end
    end

    // Words outside a test are not counted.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_left <= '0;
        end else if (load_i) begin
            rx_left <= len_i;
        end else if (busy_i && rx_step_i && !rx_done_o) begin
            rx_left <= rx_left - 1'b1;
        end
    end

endmodule

/* rtl/test_ctrl.sv */
// Test sequencing FSM with the four-phase req/ack host handshake.
// Start is raised in IDLE while req is high and acted on at the next edge.
`timescale 1ns/1ps

module test_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic req_i,
    input  logic rx_done_i,
    output logic start_o,
    output logic busy_o,
    output logic ack_o
);

    test_ctrl_pkg::state_t state;
    test_ctrl_pkg::state_t state_next;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= test_ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        case (state)
            test_ctrl_pkg::IDLE: begin
                if (req_i) begin
                    state_next = test_ctrl_pkg::RUN;
                end
            end
            test_ctrl_pkg::RUN: begin
                // All words back.
                if (rx_done_i) begin
                    state_next = test_ctrl_pkg::DONE;
                end
            end
            test_ctrl_pkg::DONE: begin
                if (!req_i) begin
                    state_next = test_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_next = test_ctrl_pkg::IDLE;
            end
        endcase
    end

    // Single cycle, since IDLE is left at the same edge.
    assign start_o = (state == test_ctrl_pkg::IDLE) && req_i;
    assign busy_o  = (state == test_ctrl_pkg::RUN);
    assign ack_o   = (state == test_ctrl_pkg::DONE);

endmodule

/* rtl/prbs_link_top.sv */
// PRBS link tester top level, connecting controller, timer, generator and checker.
// Host starts a test over req/ack; words loop through an external link.
`timescale 1ns/1ps

module prbs_link_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Host handshake.
    input  logic                  req_i,
    input  test_ctrl_pkg::count_t len_i,
    output logic                  ack_o,
    output test_ctrl_pkg::count_t err_count_o,

    // Link.
    output logic                  tx_valid_o,
    output prbs_pkg::word_t       tx_data_o,
    input  logic                  rx_valid_i,
    input  prbs_pkg::word_t       rx_data_i
);

    logic start;
    logic busy;
    logic tx_done;
    logic rx_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    test_ctrl test_ctrl_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .rx_done_i (rx_done & tx_done),
        .start_o   (start),
        .busy_o    (busy),
        .ack_o     (ack_o)
    );

    test_timer test_timer_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .load_i    (start),
        .len_i     (len_i),
        .busy_i    (busy),
        .rx_step_i (rx_valid_i),
        .tx_step_o (tx_valid_o),
        .tx_done_o (tx_done),
        .rx_done_o (rx_done)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    prbs_gen prbs_gen_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .step_i  (tx_valid_o),
        .data_o  (tx_data_o)
    );

    // Received words count only during a test.
    prbs_check prbs_check_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (start),
        .valid_i     (rx_valid_i & busy),
        .data_i      (rx_data_i),
        .err_count_o (err_count_o)
    );

endmodule

/* verification/prbs_link_sva.sv */
// Handshake and protocol assertions for the PRBS link tester.
// Bound into the top level and watching the host and link ports.
`timescale 1ns/1ps

module prbs_link_sva (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  req_i,
    input logic                  ack_i,
    input logic                  tx_valid_i,
    input test_ctrl_pkg::count_t len_i
);

    // Ack only answers a pending request.
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_i)
        else $error("ack rose while req was low");

    ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !req_i |=> !ack_i)
        else $error("ack stayed high more than one cycle after req fell");

    // A running test lies after the start cycle and before ack.
    tx_only_in_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tx_valid_i |-> (req_i && $past(req_i) && !ack_i))
        else $error("tx word sent outside a running test");

    len_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i && !ack_i) |=> $stable(len_i))
        else $error("len changed during an open request");

endmodule

bind prbs_link_top prbs_link_sva prbs_link_sva_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .ack_i      (ack_o),
    .tx_valid_i (tx_valid_o),
    .len_i      (len_i)
);

/* verification/prbs_link_tb.sv */
// Testbench for the PRBS link tester with a loopback link that adds delay and bit errors.
// Runs five back-to-back handshake tests against a reference error count.
`timescale 1ns/1ps
`include "prbs_defines.svh"

module prbs_link_tb;

    localparam int NUM_TESTS = 5;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  req_i;
    test_ctrl_pkg::count_t len_i;
    logic                  ack_o;
    test_ctrl_pkg::count_t err_count_o;
    logic                  tx_valid_o;
    prbs_pkg::word_t       tx_data_o;
    logic                  rx_valid_i;
    prbs_pkg::word_t       rx_data_i;

    // Mode 0 is clean, 1 flips random words and 2 flips the first word.
    string names[NUM_TESTS];
    int    lens[NUM_TESTS];
    int    delays[NUM_TESTS];
    int    modes[NUM_TESTS];

    integer seed;
    int     cycles;
    int     limit;
    int     checks;
    int     errors;
    string  test_name;
    int     cur_len;
    int     cur_delay;
    int     cur_mode;
    int     tx_count;
    logic   ack_checked;

    prbs_pkg::word_t tx_log[$];
    prbs_pkg::word_t rx_log[$];
    prbs_pkg::word_t pipe_word[$];
    int              pipe_due[$];

    prbs_link_top prbs_link_top_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .len_i       (len_i),
        .ack_o       (ack_o),
        .err_count_o (err_count_o),
        .tx_valid_o  (tx_valid_o),
        .tx_data_o   (tx_data_o),
        .rx_valid_i  (rx_valid_i),
        .rx_data_i   (rx_data_i)
    );

    always #20 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Returned words that do not follow the word returned before them.
    function automatic int expected_errors(input prbs_pkg::word_t words[$]);
        int n;
        n = 0;
        for (int j = 1; j < words.size(); j++) begin
            if (words[j] != prbs_pkg::next_word(words[j-1])) begin
                n++;
            end
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Loopback link
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk_i) begin
        if (tx_valid_o) begin
            if (tx_log.size() == 0) begin
                check_value({test_name, " tx first word"}, '0, tx_data_o);
            end else begin
                check_value({test_name, " tx sequence"},
                            prbs_pkg::next_word(tx_log[$]), tx_data_o);
            end
            tx_log.push_back(tx_data_o);
            tx_count++;
            pipe_word.push_back(tx_data_o);
            pipe_due.push_back(cycles + 1 + cur_delay);
        end
    end

    always @(posedge clk_i) begin : loopback_drive
        prbs_pkg::word_t word;
        int              flip_pos;
        int              roll;
        #2;
        if (pipe_due.size() > 0 && pipe_due[0] <= cycles) begin
            word = pipe_word.pop_front();
            void'(pipe_due.pop_front());
            flip_pos = $unsigned($random(seed)) % `PRBS_WIDTH;
            roll = $random(seed);
            if ((cur_mode == 1 && (roll & 3) == 0) || (cur_mode == 2 && rx_log.size() == 0)) begin
                word[flip_pos] = ~word[flip_pos];
            end
            rx_log.push_back(word);
            rx_valid_i = 1'b1;
            rx_data_i = word;
        end else begin
            rx_valid_i = 1'b0;
        end
    end

    // Compares the result once per test when ack rises.
    always @(negedge clk_i) begin
        if (rst_n_i && ack_o && !ack_checked) begin
            ack_checked = 1'b1;
            check_value({test_name, " tx words"}, cur_len, tx_count);
            check_value({test_name, " rx words"}, cur_len, rx_log.size());
            check_value({test_name, " err_count"}, expected_errors(rx_log), err_count_o);
            if (cur_mode == 0) begin
                check_value({test_name, " clean count"}, 0, err_count_o);
            end else if (cur_mode == 2) begin
                check_value({test_name, " seeded count"}, 1, err_count_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", limit);
            $display("Checks run: %0d, mismatches: %0d", checks, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic configure_tests();
        names[0] = "clean_len8";
        lens[0] = 8;
        delays[0] = 0;
        modes[0] = 0;
        names[1] = "random_err_a";
        lens[1] = 16 + ($unsigned($random(seed)) % 32);
        delays[1] = $unsigned($random(seed)) % 6;
        modes[1] = 1;
        names[2] = "long_delay";
        lens[2] = 20;
        delays[2] = 12;
        modes[2] = 0;
        names[3] = "random_err_b";
        lens[3] = 16 + ($unsigned($random(seed)) % 32);
        delays[3] = $unsigned($random(seed)) % 6;
        modes[3] = 1;
        names[4] = "first_word_err";
        lens[4] = 10;
        delays[4] = 2;
        modes[4] = 2;
    endtask

    task automatic run_test(input int idx);
        test_name = names[idx];
        cur_len = lens[idx];
        cur_delay = delays[idx];
        cur_mode = modes[idx];
        tx_count = 0;
        rx_log.delete();
        ack_checked = 1'b0;
        @(posedge clk_i);
        #2;
        len_i = test_ctrl_pkg::count_t'(cur_len);
        @(posedge clk_i);
        #2;
        req_i = 1'b1;
        // The start edge clears the checker.
        @(posedge clk_i);
        @(negedge clk_i);
        check_value({test_name, " cleared count"}, 0, err_count_o);
        while (!ack_o) begin
            @(negedge clk_i);
        end
        repeat (2) begin
            @(negedge clk_i);
            check_value({test_name, " ack held"}, 1, ack_o);
        end
        @(posedge clk_i);
        #2;
        req_i = 1'b0;
        @(negedge clk_i);
        check_value({test_name, " ack before release"}, 1, ack_o);
        @(negedge clk_i);
        check_value({test_name, " ack release"}, 0, ack_o);
    endtask

    initial begin
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        req_i = 1'b0;
        len_i = '0;
        rx_valid_i = 1'b0;
        rx_data_i = '0;
        seed = 36957;
        cycles = 0;
        checks = 0;
        errors = 0;
        cur_len = 0;
        cur_delay = 0;
        cur_mode = 0;
        tx_count = 0;
        test_name = "reset";
        ack_checked = 1'b1;
        configure_tests();
        limit = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += lens[i] + delays[i] + 20;
        end
        repeat (5) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        repeat (2) @(posedge clk_i);
        $display("Checks run: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/prbs_pkg.sv
rtl/test_ctrl_pkg.sv
rtl/prbs_gen.sv
rtl/prbs_check.sv
rtl/test_timer.sv
rtl/test_ctrl.sv
rtl/prbs_link_top.sv
verification/prbs_link_sva.sv
verification/prbs_link_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the PRBS link tester with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module prbs_link_tb \
    -Mdir obj_dir -f all.f && ./obj_dir/Vprbs_link_tb; } > "$LOG" 2>&1 \
    || echo "Some tests failed" >> "$LOG"
cat "$LOG"
grep -q "Some tests failed" "$LOG" && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
